// File: src/spu_settings.svh
`ifndef SPU_SETTINGS_SVH
`define SPU_SETTINGS_SVH

// operand and result width
`define SPU_DATA_BITS 16

// lane latency in enabled cycles, at least 1
`define SPU_LATENCY 2

// loaded into the data stages on clear
`define SPU_CLEAR_DATA {`SPU_DATA_BITS{1'b0}}

`endif

// File: src/spu_pkg.sv
`default_nettype none

`include "spu_settings.svh"

package spu_pkg;

    typedef logic [`SPU_DATA_BITS-1:0] data_t;

    // code 7 has no name and behaves as OP_NOP
    typedef enum logic [2:0] {
        OP_NOP = 3'd0,  // a
        OP_NOT = 3'd1,  // ~a
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_ADD = 3'd5,  // a + b, carry out
        OP_SUB = 3'd6   // a - b, borrow out
    } opcode_t;

    typedef enum logic [1:0] {
        UNIT_PASS  = 2'd0,
        UNIT_NOT   = 2'd1,
        UNIT_LOGIC = 2'd2,
        UNIT_ARITH = 2'd3
    } unit_t;

    function automatic unit_t unit_of(input opcode_t op);
        unit_t unit;
        case (op)
            OP_NOT:                unit = UNIT_NOT;
            OP_AND, OP_OR, OP_XOR: unit = UNIT_LOGIC;
            OP_ADD, OP_SUB:        unit = UNIT_ARITH;
            default:               unit = UNIT_PASS;  // nop and code 7
        endcase
        return unit;
    endfunction

endpackage

`default_nettype wire

// File: src/spu_op_if.sv
`default_nettype none

// one operation, fanned out from the top level to every block
interface spu_op_if;

    spu_pkg::data_t   a;      // first operand
    spu_pkg::data_t   b;      // second operand
    spu_pkg::opcode_t op;
    logic             clear;  // one-cycle pulse
    logic             valid;  // level, qualifies the operands

    modport core (
        output a,
        output b,
        output op,
        output clear,
        output valid
    );

    modport unit (
        input  a,
        input  b,
        input  op,
        input  clear,
        input  valid
    );

endinterface

`default_nettype wire

// File: src/spu_op_nop.sv
`default_nettype none

`include "spu_settings.svh"

module spu_op_nop #(
    parameter int LATENCY   = 1,     // register stages, 0 is a wire
    parameter bit USE_VALID = 1'b1   // hold data stages on invalid slots
) (
    input  var logic           clk,
    input  var logic           rst_n,
    input  var logic           cke,

    input  var spu_pkg::data_t s_data,
    input  var logic           s_clear,
    input  var logic           s_valid,

    output spu_pkg::data_t     m_data
);

    generate
        if (LATENCY == 0) begin : g_wire
            assign m_data = s_data;
        end else begin : g_chain
            spu_pkg::data_t     stg_data [LATENCY];
            logic [LATENCY-1:0] stg_clear;  // clear bit travelling with each stage
            logic [LATENCY-1:0] stg_valid;  // valid bit travelling with each stage

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < LATENCY; i++) begin
                        stg_data[i] <= `SPU_CLEAR_DATA;
                    end
                    stg_clear <= '0;
                    stg_valid <= '0;
                end else if (cke) begin
                    // first stage takes the input
                    if (s_clear) begin
                        stg_data[0] <= `SPU_CLEAR_DATA;
                    end else if (s_valid || !USE_VALID) begin
                        stg_data[0] <= s_data;
                    end
                    stg_clear[0] <= s_clear;
                    stg_valid[0] <= s_valid;

                    for (int i = 1; i < LATENCY; i++) begin
                        if (stg_clear[i-1]) begin
                            stg_data[i] <= `SPU_CLEAR_DATA;
                        end else if (stg_valid[i-1] || !USE_VALID) begin
                            stg_data[i] <= stg_data[i-1];
                        end
                        stg_clear[i] <= stg_clear[i-1];  // flags shift every enabled cycle
                        stg_valid[i] <= stg_valid[i-1];
                    end
                end
            end

            assign m_data = stg_data[LATENCY-1];
        end
    endgenerate

endmodule

`default_nettype wire

// File: src/spu_op_not.sv
`default_nettype none

`include "spu_settings.svh"

module spu_op_not (
    input  var logic       clk,
    input  var logic       rst_n,
    input  var logic       cke,

    spu_op_if.unit         op,

    output spu_pkg::data_t m_data
);

    spu_pkg::data_t st0_data;

    assign st0_data = ~op.a;  // not

    spu_op_nop #(
        .LATENCY   (`SPU_LATENCY),
        .USE_VALID (1'b1)
    ) u_delay (
        .clk       (clk),
        .rst_n     (rst_n),
        .cke       (cke),
        .s_data    (st0_data),
        .s_clear   (op.clear),
        .s_valid   (op.valid),
        .m_data    (m_data)
    );

endmodule

`default_nettype wire

// File: src/spu_op_logic.sv
`default_nettype none

`include "spu_settings.svh"

module spu_op_logic (
    input  var logic       clk,
    input  var logic       rst_n,
    input  var logic       cke,

    spu_op_if.unit         op,

    output spu_pkg::data_t m_data
);

    spu_pkg::data_t st0_data;

    always_comb begin
        case (op.op)
            spu_pkg::OP_AND: st0_data = op.a & op.b;
            spu_pkg::OP_OR:  st0_data = op.a | op.b;
            spu_pkg::OP_XOR: st0_data = op.a ^ op.b;
            default:         st0_data = '0;  // not a logic op
        endcase
    end

    spu_op_nop #(
        .LATENCY   (`SPU_LATENCY),
        .USE_VALID (1'b1)
    ) u_delay (
        .clk       (clk),
        .rst_n     (rst_n),
        .cke       (cke),
        .s_data    (st0_data),
        .s_clear   (op.clear),
        .s_valid   (op.valid),
        .m_data    (m_data)
    );

endmodule

`default_nettype wire

// File: src/spu_op_add.sv
`default_nettype none

`include "spu_settings.svh"

module spu_op_add (
    input  var logic       clk,
    input  var logic       rst_n,
    input  var logic       cke,

    spu_op_if.unit         op,

    output spu_pkg::data_t m_data,
    output logic           m_carry
);

    logic [`SPU_DATA_BITS:0] st0_sum;    // one extra bit for carry or borrow
    spu_pkg::data_t          st0_data;
    spu_pkg::data_t          st0_carry;  // carry in bit 0
    spu_pkg::data_t          carry_dly;

    always_comb begin
        if (op.op == spu_pkg::OP_SUB) begin
            st0_sum = {1'b0, op.a} - {1'b0, op.b};  // top bit set when a < b
        end else begin
            st0_sum = {1'b0, op.a} + {1'b0, op.b};
        end
    end

    assign st0_data  = st0_sum[`SPU_DATA_BITS-1:0];
    assign st0_carry = {{(`SPU_DATA_BITS-1){1'b0}}, st0_sum[`SPU_DATA_BITS]};

    spu_op_nop #(
        .LATENCY   (`SPU_LATENCY),
        .USE_VALID (1'b1)
    ) u_delay_sum (
        .clk       (clk),
        .rst_n     (rst_n),
        .cke       (cke),
        .s_data    (st0_data),
        .s_clear   (op.clear),
        .s_valid   (op.valid),
        .m_data    (m_data)
    );

    spu_op_nop #(
        .LATENCY   (`SPU_LATENCY),
        .USE_VALID (1'b1)
    ) u_delay_carry (
        .clk       (clk),
        .rst_n     (rst_n),
        .cke       (cke),
        .s_data    (st0_carry),
        .s_clear   (op.clear),
        .s_valid   (op.valid),
        .m_data    (carry_dly)
    );

    assign m_carry = carry_dly[0];

endmodule

`default_nettype wire

// File: src/spu_core.sv
`default_nettype none

`include "spu_settings.svh"

module spu_core (
    input  var logic             clk,
    input  var logic             rst_n,
    input  var logic             cke,

    input  var spu_pkg::opcode_t op,
    input  var spu_pkg::data_t   a,
    input  var spu_pkg::data_t   b,
    input  var logic             clear,
    input  var logic             valid,

    output spu_pkg::data_t       m_data,
    output logic                 m_carry,
    output logic                 m_valid
);

    spu_op_if op_bus ();

    spu_pkg::unit_t last_unit;  // unit of the latest valid operation
    spu_pkg::unit_t unit_in;
    spu_pkg::unit_t unit_dly;
    spu_pkg::data_t sel_word;
    spu_pkg::data_t sel_dly;
    spu_pkg::data_t vld_word;
    spu_pkg::data_t vld_dly;
    spu_pkg::data_t pass_data;
    spu_pkg::data_t not_data;
    spu_pkg::data_t logic_data;
    spu_pkg::data_t add_data;
    logic           add_carry;

    assign op_bus.a     = a;
    assign op_bus.b     = b;
    assign op_bus.op    = op;
    assign op_bus.clear = clear;
    assign op_bus.valid = valid;

    // an invalid slot keeps showing the last valid unit, whose data is held
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_unit <= spu_pkg::UNIT_PASS;
        end else if (cke && valid) begin
            last_unit <= spu_pkg::unit_of(op);
        end
    end

    assign unit_in  = valid ? spu_pkg::unit_of(op) : last_unit;
    assign sel_word = {{(`SPU_DATA_BITS-2){1'b0}}, unit_in};
    assign vld_word = {{(`SPU_DATA_BITS-1){1'b0}}, valid & ~clear};

    spu_op_not   u_op_not   (.clk(clk), .rst_n(rst_n), .cke(cke), .op(op_bus),
                             .m_data(not_data));
    spu_op_logic u_op_logic (.clk(clk), .rst_n(rst_n), .cke(cke), .op(op_bus),
                             .m_data(logic_data));
    spu_op_add   u_op_add   (.clk(clk), .rst_n(rst_n), .cke(cke), .op(op_bus),
                             .m_data(add_data), .m_carry(add_carry));

    spu_op_nop #(.LATENCY(`SPU_LATENCY), .USE_VALID(1'b1)) u_pass (
        .clk(clk), .rst_n(rst_n), .cke(cke),
        .s_data(a), .s_clear(clear), .s_valid(valid),
        .m_data(pass_data)
    );

    // select and valid shift every enabled cycle
    spu_op_nop #(.LATENCY(`SPU_LATENCY), .USE_VALID(1'b0)) u_sel_delay (
        .clk(clk), .rst_n(rst_n), .cke(cke),
        .s_data(sel_word), .s_clear(1'b0), .s_valid(valid),
        .m_data(sel_dly)
    );

    spu_op_nop #(.LATENCY(`SPU_LATENCY), .USE_VALID(1'b0)) u_vld_delay (
        .clk(clk), .rst_n(rst_n), .cke(cke),
        .s_data(vld_word), .s_clear(1'b0), .s_valid(valid),
        .m_data(vld_dly)
    );

    assign unit_dly = spu_pkg::unit_t'(sel_dly[1:0]);

    always_comb begin
        case (unit_dly)
            spu_pkg::UNIT_NOT:   m_data = not_data;
            spu_pkg::UNIT_LOGIC: m_data = logic_data;
            spu_pkg::UNIT_ARITH: m_data = add_data;
            default:             m_data = pass_data;
        endcase
    end

    assign m_carry = (unit_dly == spu_pkg::UNIT_ARITH) & add_carry;
    assign m_valid = vld_dly[0];

endmodule

`default_nettype wire

// File: test/tb_spu_core.sv
`default_nettype none

`include "spu_settings.svh"

module tb_spu_core;

    localparam int NUM_ROWS      = 30;
    localparam int NUM_RANDOM    = 200;
    localparam int RESET_TIMEOUT = 20;  // in clock cycles

    typedef struct packed {
        spu_pkg::opcode_t op;
        spu_pkg::data_t   a;
        spu_pkg::data_t   b;
        logic             clear;
        logic             valid;
        logic             cke;
        spu_pkg::data_t   exp_data;   // output expected for this slot
        logic             exp_carry;
    } row_t;

    typedef struct packed {
        spu_pkg::data_t data;
        logic           carry;
        logic           valid;
    } out_t;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             cke;
    spu_pkg::opcode_t op;
    spu_pkg::data_t   a;
    spu_pkg::data_t   b;
    logic             clear;
    logic             valid;
    spu_pkg::data_t   m_data;
    logic             m_carry;
    logic             m_valid;

    row_t        table_rows [NUM_ROWS];
    out_t        exp_q [$];   // slots still inside the lane
    out_t        cur_out;     // what the outputs show now
    out_t        last_out;    // latest slot pushed and held by invalid slots
    logic [31:0] lfsr_state;
    int          slot_count;

    spu_core spu_core_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .op      (op),
        .a       (a),
        .b       (b),
        .clear   (clear),
        .valid   (valid),
        .m_data  (m_data),
        .m_carry (m_carry),
        .m_valid (m_valid)
    );

    always #20 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input spu_pkg::data_t got,
                              input spu_pkg::data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED %s got %h expected %h at slot %0d",
                               name, got, exp, slot_count));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED %s got %h expected %h at slot %0d",
                               name, got, exp, slot_count));
        end
    endtask

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};  // one step per bit
        end
        return v;
    endfunction

    // opcode rules with the carry in the top bit
    function automatic logic [`SPU_DATA_BITS:0] expected_of(input spu_pkg::opcode_t o,
                                                            input spu_pkg::data_t x,
                                                            input spu_pkg::data_t y);
        logic [`SPU_DATA_BITS:0] res;
        case (o)
            spu_pkg::OP_NOT: res = {1'b0, ~x};
            spu_pkg::OP_AND: res = {1'b0, x & y};
            spu_pkg::OP_OR:  res = {1'b0, x | y};
            spu_pkg::OP_XOR: res = {1'b0, x ^ y};
            spu_pkg::OP_ADD: res = {(x + y) < x, x + y};  // carry when the sum wraps
            spu_pkg::OP_SUB: res = {x < y, x - y};         // borrow when x below y
            default:         res = {1'b0, x};              // nop and code 7
        endcase
        return res;
    endfunction

    function automatic row_t random_row();
        row_t                    r;
        logic [31:0]             bits;
        logic [`SPU_DATA_BITS:0] res;
        bits    = rand_bits(3);
        r.op    = spu_pkg::opcode_t'(bits[2:0]);
        bits    = rand_bits(`SPU_DATA_BITS);
        r.a     = bits[`SPU_DATA_BITS-1:0];
        bits    = rand_bits(`SPU_DATA_BITS);
        r.b     = bits[`SPU_DATA_BITS-1:0];
        bits    = rand_bits(5);
        r.clear = (bits[4:0] == 5'd0);  // rare
        bits    = rand_bits(3);
        r.valid = (bits[2:0] != 3'd0);
        bits    = rand_bits(3);
        r.cke   = (bits[2:0] != 3'd0);
        res     = expected_of(r.op, r.a, r.b);
        if (r.clear) begin
            r.exp_data  = `SPU_CLEAR_DATA;
            r.exp_carry = 1'b0;
        end else if (!r.valid) begin
            r.exp_data  = last_out.data;
            r.exp_carry = last_out.carry;
        end else begin
            r.exp_data  = res[`SPU_DATA_BITS-1:0];
            r.exp_carry = res[`SPU_DATA_BITS];
        end
        return r;
    endfunction

    // check what the lane shows, then present the next row
    task automatic apply_slot(input row_t r);
        out_t slot;
        @(negedge clk);
        check_data("m_data", m_data, cur_out.data);
        check_flag("m_carry", m_carry, cur_out.carry);
        check_flag("m_valid", m_valid, cur_out.valid);
        op    = r.op;
        a     = r.a;
        b     = r.b;
        clear = r.clear;
        valid = r.valid;
        cke   = r.cke;
        if (r.cke) begin  // only enabled edges move the lane
            slot.data  = r.exp_data;
            slot.carry = r.exp_carry;
            slot.valid = r.valid & ~r.clear;
            exp_q.push_back(slot);
            cur_out  = exp_q.pop_front();
            last_out = slot;
        end
        slot_count++;
    endtask

    initial begin
        row_t idle;
        int   wait_cycles;
        cke        = 1'b0;
        op         = spu_pkg::OP_NOP;
        a          = '0;
        b          = '0;
        clear      = 1'b0;
        valid      = 1'b0;
        lfsr_state = 32'hf37e0bca;
        slot_count = 0;
        cur_out    = '0;
        last_out   = '0;
        for (int i = 0; i < `SPU_LATENCY - 1; i++) begin
            exp_q.push_back('0);  // reset contents of the lane
        end

        //  op                         a        b        clr   vld   cke   data     carry
        table_rows = '{
            '{spu_pkg::OP_NOP, 16'h1234, 16'h5678, 1'b0, 1'b1, 1'b1, 16'h1234, 1'b0},
            '{spu_pkg::OP_NOT, 16'h00ff, 16'h0000, 1'b0, 1'b1, 1'b1, 16'hff00, 1'b0},
            '{spu_pkg::OP_AND, 16'hf0f0, 16'hff00, 1'b0, 1'b1, 1'b1, 16'hf000, 1'b0},
            '{spu_pkg::OP_OR,  16'hf0f0, 16'h0f0f, 1'b0, 1'b1, 1'b1, 16'hffff, 1'b0},
            '{spu_pkg::OP_XOR, 16'haaaa, 16'hffff, 1'b0, 1'b1, 1'b1, 16'h5555, 1'b0},
            '{spu_pkg::OP_ADD, 16'h1234, 16'h1111, 1'b0, 1'b1, 1'b1, 16'h2345, 1'b0},
            '{spu_pkg::OP_ADD, 16'hffff, 16'h0001, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b1},
            '{spu_pkg::OP_SUB, 16'h0000, 16'h0001, 1'b0, 1'b1, 1'b1, 16'hffff, 1'b1},
            '{spu_pkg::OP_SUB, 16'h5000, 16'h1000, 1'b0, 1'b1, 1'b1, 16'h4000, 1'b0},
            '{spu_pkg::opcode_t'(3'd7), 16'habcd, 16'h1111, 1'b0, 1'b1, 1'b1, 16'habcd, 1'b0},
            '{spu_pkg::OP_ADD, 16'h8000, 16'h8000, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b1},
            '{spu_pkg::OP_SUB, 16'h1234, 16'h1234, 1'b0, 1'b1, 1'b1, 16'h0000, 1'b0},
            '{spu_pkg::OP_XOR, 16'h00ff, 16'h0f0f, 1'b0, 1'b1, 1'b1, 16'h0ff0, 1'b0},
            '{spu_pkg::OP_ADD, 16'h0001, 16'h0002, 1'b1, 1'b1, 1'b1, 16'h0000, 1'b0},
            '{spu_pkg::OP_OR,  16'h1000, 16'h0001, 1'b0, 1'b1, 1'b1, 16'h1001, 1'b0},
            '{spu_pkg::OP_ADD, 16'hffff, 16'hffff, 1'b0, 1'b1, 1'b1, 16'hfffe, 1'b1},
            '{spu_pkg::OP_NOT, 16'h1111, 16'h0000, 1'b0, 1'b0, 1'b1, 16'hfffe, 1'b1},
            '{spu_pkg::OP_SUB, 16'h0001, 16'h0002, 1'b0, 1'b0, 1'b1, 16'hfffe, 1'b1},
            '{spu_pkg::OP_NOT, 16'h0000, 16'h0000, 1'b0, 1'b1, 1'b1, 16'hffff, 1'b0},
            '{spu_pkg::OP_ADD, 16'h1111, 16'h1111, 1'b0, 1'b1, 1'b0, 16'h0000, 1'b0},
            '{spu_pkg::OP_SUB, 16'h2222, 16'h1111, 1'b0, 1'b1, 1'b0, 16'h0000, 1'b0},
            '{spu_pkg::OP_AND, 16'h3333, 16'h1111, 1'b0, 1'b1, 1'b0, 16'h0000, 1'b0},
            '{spu_pkg::OP_AND, 16'hffff, 16'h1234, 1'b0, 1'b1, 1'b1, 16'h1234, 1'b0},
            '{spu_pkg::OP_SUB, 16'h0001, 16'h0002, 1'b0, 1'b1, 1'b1, 16'hffff, 1'b1},
            '{spu_pkg::OP_ADD, 16'h0005, 16'h0006, 1'b1, 1'b0, 1'b1, 16'h0000, 1'b0},
            '{spu_pkg::OP_NOT, 16'h4444, 16'h0000, 1'b0, 1'b0, 1'b1, 16'h0000, 1'b0},
            '{spu_pkg::OP_NOP, 16'h7777, 16'h0000, 1'b0, 1'b1, 1'b1, 16'h7777, 1'b0},
            '{spu_pkg::OP_XOR, 16'h1234, 16'h4321, 1'b0, 1'b1, 1'b0, 16'h0000, 1'b0},
            '{spu_pkg::OP_ADD, 16'h7fff, 16'h0001, 1'b0, 1'b1, 1'b1, 16'h8000, 1'b0},
            '{spu_pkg::opcode_t'(3'd7), 16'hffff, 16'h0000, 1'b0, 1'b1, 1'b1, 16'hffff, 1'b0}
        };

        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            fail_run("reset was never released");
        end
        check_data("m_data", m_data, '0);  // values right after reset
        check_flag("m_carry", m_carry, 1'b0);
        check_flag("m_valid", m_valid, 1'b0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_slot(table_rows[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            apply_slot(random_row());
        end

        // flush the lane with idle slots
        for (int i = 0; i < `SPU_LATENCY; i++) begin
            idle           = '0;
            idle.cke       = 1'b1;
            idle.exp_data  = last_out.data;
            idle.exp_carry = last_out.carry;
            apply_slot(idle);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/spu_pkg.sv
src/spu_op_if.sv
src/spu_op_nop.sv
src/spu_op_not.sv
src/spu_op_logic.sv
src/spu_op_add.sv
src/spu_core.sv
test/tb_spu_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_spu_core
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
